// File: flist.f
rtl/axil_route_pkg.sv
rtl/bar_decoder.sv
rtl/route_hold.sv
rtl/write_steer.sv
rtl/read_steer.sv
rtl/axil_bar_router.sv
dv/router_checker.sv
dv/router_sva.sv
dv/tb_axil_bar_router.sv

// File: dv/router_golden.txt
// kind_addr_func_vfg_bardec_data_strb_target, kind 1 write 2 read 0 end
// target 1 mailbox 0 external, reads carry strb 0
// pf0 bar0 dma bar
1_00001000_00_0_0_cafe0001_f_1
2_00001004_00_0_0_12345678_0_1
// pf0 bar4 not a dma bar
1_00002000_00_0_4_a5a50002_3_0
2_00002004_00_0_4_0f0f0f0f_0_0
// bar2 mailbox-only on pf1
2_00003000_01_0_2_11112222_0_1
2_00003004_00_0_2_33334444_0_0
1_00003008_01_0_2_55556666_c_1
1_0000300c_01_0_1_77778888_f_1
// vf groups
2_00004000_04_1_3_9999aaaa_0_1
2_00004004_05_0_3_bbbbcccc_0_0
1_00004008_08_0_0_ddddeeee_5_1
1_0000400c_10_1_3_01020304_a_1
2_00004010_04_2_3_05060708_0_0
// bardec 6 and 7 hit nothing
1_00005000_00_0_6_13572468_f_0
2_00005004_00_0_7_24681357_0_0
2_00005008_04_0_6_feedbeef_0_0
1_0000500c_01_1_7_c0ffee00_f_0
// pf2 and pf3 have no dma bars
2_00006000_02_0_0_abcdef01_0_0
1_00006004_03_0_2_10203040_f_0
2_00006008_01_0_0_50607080_0_0
1_0000600c_00_0_0_90a0b0c0_1_1
2_00006010_01_3_1_d0e0f001_0_1
1_00006014_04_3_0_8899aabb_f_0
0_00000000_00_0_0_00000000_0_0

// File: dv/tb_axil_bar_router.sv
`timescale 1ns/1ps

// answers one request at a time with random ready delay
module target_model
  import axil_route_pkg::*;
#(
  parameter logic [1:0] resp_code = resp_okay,
  parameter bit         invert    = 1'b0
)
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic [data_w-1:0] row_data,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic              w_valid,
  output logic              w_ready,
  output axil_b_t           b,
  output logic              b_valid,
  input  logic              b_ready,
  input  logic              ar_valid,
  output logic              ar_ready,
  output axil_r_t           r,
  output logic              r_valid,
  input  logic              r_ready
);

  integer seed = 4;

  // 0 to 3 cycles of back-pressure
  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  // write side, aw and w taken together
  initial
  begin
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    b_valid  = 1'b0;
    b        = '0;
    forever
    begin
      @(posedge clk);
      if (reset_n && aw_valid && w_valid)
      begin
        repeat (pick_delay()) @(posedge clk);
        #2;
        aw_ready = 1'b1;
        w_ready  = 1'b1;
        @(posedge clk);
        #2;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b.resp   = resp_code;
        b_valid  = 1'b1;
        @(posedge clk);
        while (!b_ready)
          @(posedge clk);
        #2;
        b_valid = 1'b0;
      end
    end
  end

  // read side
  initial
  begin
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r        = '0;
    forever
    begin
      @(posedge clk);
      if (reset_n && ar_valid)
      begin
        repeat (pick_delay()) @(posedge clk);
        #2;
        ar_ready = 1'b1;
        @(posedge clk);
        #2;
        ar_ready = 1'b0;
        r.data   = invert ? ~row_data : row_data;
        r.resp   = resp_code;
        r_valid  = 1'b1;
        @(posedge clk);
        while (!r_ready)
          @(posedge clk);
        #2;
        r_valid = 1'b0;
      end
    end
  end

endmodule

module tb_axil_bar_router
  import axil_route_pkg::*;
();

  localparam int max_rows = 64;
  // pf3..pf0, extra mailbox bar 2 on pf1 only
  localparam bar_mask_t [num_pf-1:0] mb_pf = {6'b000000, 6'b000000, 6'b000100, 6'b000000};

  logic      clk;
  logic      reset_n;
  bar_attr_t bar_attr;

  // slave side
  axil_aw_t s_aw;
  logic     s_aw_valid, s_aw_ready;
  axil_w_t  s_w;
  logic     s_w_valid, s_w_ready;
  axil_b_t  s_b;
  logic     s_b_valid, s_b_ready;
  axil_ar_t s_ar;
  logic     s_ar_valid, s_ar_ready;
  axil_r_t  s_r;
  logic     s_r_valid, s_r_ready;

  // mailbox side
  axil_aw_t mb_aw;
  logic     mb_aw_valid, mb_aw_ready;
  axil_w_t  mb_w;
  logic     mb_w_valid, mb_w_ready;
  axil_b_t  mb_b;
  logic     mb_b_valid, mb_b_ready;
  axil_ar_t mb_ar;
  logic     mb_ar_valid, mb_ar_ready;
  axil_r_t  mb_r;
  logic     mb_r_valid, mb_r_ready;

  // external side
  axil_aw_t ext_aw;
  logic     ext_aw_valid, ext_aw_ready;
  axil_w_t  ext_w;
  logic     ext_w_valid, ext_w_ready;
  axil_b_t  ext_b;
  logic     ext_b_valid, ext_b_ready;
  axil_ar_t ext_ar;
  logic     ext_ar_valid, ext_ar_ready;
  axil_r_t  ext_r;
  logic     ext_r_valid, ext_r_ready;

  // golden rows and expectations handed to the checker
  logic [91:0]       golden [0:max_rows-1];
  int                n_rows;
  int                row_idx;
  logic              exp_mb;
  axil_aw_t          exp_req;
  axil_w_t           exp_w;
  logic [data_w-1:0] exp_data;
  int                err_count;
  int                done_count;
  int                tb_errors;
  int                cycle_count = 0;
  int                cycle_limit;

  axil_bar_router #(
    .barlite_mb_pf (mb_pf)
  ) dut0 (.*);

  router_checker u_checker (.*);

  target_model #(
    .resp_code (resp_okay),
    .invert    (1'b0)
  ) u_mb_model (
    .clk      (clk),
    .reset_n  (reset_n),
    .row_data (exp_data),
    .aw_valid (mb_aw_valid),
    .aw_ready (mb_aw_ready),
    .w_valid  (mb_w_valid),
    .w_ready  (mb_w_ready),
    .b        (mb_b),
    .b_valid  (mb_b_valid),
    .b_ready  (mb_b_ready),
    .ar_valid (mb_ar_valid),
    .ar_ready (mb_ar_ready),
    .r        (mb_r),
    .r_valid  (mb_r_valid),
    .r_ready  (mb_r_ready)
  );

  target_model #(
    .resp_code (resp_slverr),
    .invert    (1'b1)
  ) u_ext_model (
    .clk      (clk),
    .reset_n  (reset_n),
    .row_data (exp_data),
    .aw_valid (ext_aw_valid),
    .aw_ready (ext_aw_ready),
    .w_valid  (ext_w_valid),
    .w_ready  (ext_w_ready),
    .b        (ext_b),
    .b_valid  (ext_b_valid),
    .b_ready  (ext_b_ready),
    .ar_valid (ext_ar_valid),
    .ar_ready (ext_ar_ready),
    .r        (ext_r),
    .r_valid  (ext_r_valid),
    .r_ready  (ext_r_ready)
  );

  //////////////////////////////
  // clock and timeout
  //////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout after %0d cycles, a transaction never completed", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // rows end at the first kind that is not write or read
  function automatic int count_rows();
    int n;
    n = 0;
    while (n < max_rows && (golden[n][91:88] == 4'h1 || golden[n][91:88] == 4'h2))
      n++;
    return n;
  endfunction

  task automatic drive_write(input axil_aw_t req, input axil_w_t wd);
    logic aw_done;
    logic w_done;
    logic b_done;
    aw_done    = 1'b0;
    w_done     = 1'b0;
    b_done     = 1'b0;
    s_aw       = req;
    s_w        = wd;
    s_aw_valid = 1'b1;
    s_w_valid  = 1'b1;
    s_b_ready  = 1'b1;
    while (!b_done)
    begin
      @(posedge clk);
      if (s_aw_valid && s_aw_ready)
        aw_done = 1'b1;
      if (s_w_valid && s_w_ready)
        w_done = 1'b1;
      if (s_b_valid && s_b_ready)
        b_done = 1'b1;
      #2;
      if (aw_done)
        s_aw_valid = 1'b0;
      if (w_done)
        s_w_valid = 1'b0;
    end
    s_b_ready = 1'b0;
  endtask

  task automatic drive_read(input axil_ar_t req);
    logic ar_done;
    logic r_done;
    ar_done    = 1'b0;
    r_done     = 1'b0;
    s_ar       = req;
    s_ar_valid = 1'b1;
    s_r_ready  = 1'b1;
    while (!r_done)
    begin
      @(posedge clk);
      if (s_ar_valid && s_ar_ready)
        ar_done = 1'b1;
      if (s_r_valid && s_r_ready)
        r_done = 1'b1;
      #2;
      if (ar_done)
        s_ar_valid = 1'b0;
    end
    s_r_ready = 1'b0;
  endtask

  // unpack one golden row, publish expectations, run it
  task automatic run_row(input int idx);
    logic [91:0] row;
    axil_aw_t    req;
    axil_w_t     wd;
    row             = golden[idx];
    req.addr        = row[87:56];
    req.user.func   = row[55:48];
    req.user.vfg    = row[45:44];
    req.user.bardec = row[42:40];
    wd.data         = row[39:8];
    wd.strb         = row[7:4];
    row_idx         = idx;
    exp_mb          = row[0];
    exp_req         = req;
    exp_w           = wd;
    exp_data        = wd.data;
    if (row[91:88] == 4'h1)
      drive_write(req, wd);
    else
      drive_read(req);
    // one idle cycle between rows
    @(posedge clk);
    #2;
  endtask

  initial
  begin
    reset_n                = 1'b0;
    // requests pending through reset must not leak to a target
    s_aw                   = '0;
    s_aw_valid             = 1'b1;
    s_w                    = '0;
    s_w_valid              = 1'b1;
    s_b_ready              = 1'b0;
    s_ar                   = '0;
    s_ar_valid             = 1'b1;
    s_r_ready              = 1'b0;
    // pf0 bar0, pf1 bar1; vf group0 bar0, group1 bar3
    bar_attr.pf_barlite    = {6'b000000, 6'b000000, 6'b000010, 6'b000001};
    bar_attr.pf_vf_barlite = {6'b000000, 6'b000000, 6'b001000, 6'b000001};
    row_idx                = -1;
    exp_mb                 = 1'b0;
    exp_req                = '0;
    exp_w                  = '0;
    exp_data               = '0;
    tb_errors              = 0;
    $readmemh("dv/router_golden.txt", golden);
    n_rows      = count_rows();
    cycle_limit = n_rows * 12 + 50;
    if (n_rows == 0)
    begin
      $display("the golden file holds no transactions");
      tb_errors++;
    end
    repeat (16) @(posedge clk);
    #2;
    reset_n    = 1'b1;
    s_aw_valid = 1'b0;
    s_w_valid  = 1'b0;
    s_ar_valid = 1'b0;
    @(posedge clk);
    #2;
    for (int i = 0; i < n_rows; i++)
      run_row(i);
    repeat (2) @(posedge clk);
    // each row must finish exactly once
    if (done_count != n_rows)
    begin
      $display("%0d responses completed for %0d golden rows", done_count, n_rows);
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d", err_count, tb_errors);
    if (err_count + tb_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: dv/router_sva.sv
`timescale 1ns/1ps

module router_sva
(
  input logic clk,
  input logic reset_n,
  input logic wr_active,
  input logic rd_active,
  input logic s_aw_ready,
  input logic s_w_ready,
  input logic s_ar_ready,
  input logic s_b_valid,
  input logic s_r_valid,
  input logic mb_aw_valid,
  input logic mb_w_valid,
  input logic mb_ar_valid,
  input logic ext_aw_valid,
  input logic ext_w_valid,
  input logic ext_ar_valid
);

  logic any_valid;

  assign any_valid = mb_aw_valid | mb_w_valid | mb_ar_valid | ext_aw_valid
                   | ext_w_valid | ext_ar_valid | s_b_valid | s_r_valid;

  //////////////////////////////
  // one target per channel
  //////////////////////////////

  a_aw_one_target: assert property (@(posedge clk) disable iff (!reset_n)
    !(mb_aw_valid && ext_aw_valid))
    else $error("aw valid reached both targets");

  a_w_one_target: assert property (@(posedge clk) disable iff (!reset_n)
    !(mb_w_valid && ext_w_valid))
    else $error("w valid reached both targets");

  a_ar_one_target: assert property (@(posedge clk) disable iff (!reset_n)
    !(mb_ar_valid && ext_ar_valid))
    else $error("ar valid reached both targets");

  //////////////////////////////
  // idle channel, no ready
  //////////////////////////////

  a_wr_idle_ready: assert property (@(posedge clk) disable iff (!reset_n)
    !wr_active |-> !s_aw_ready && !s_w_ready)
    else $error("write ready high on an idle channel");

  a_rd_idle_ready: assert property (@(posedge clk) disable iff (!reset_n)
    !rd_active |-> !s_ar_ready)
    else $error("read ready high on an idle channel");

  // every valid low once reset is seen
  a_reset_quiet: assert property (@(posedge clk) !reset_n |=> !any_valid)
    else $error("valid output high in the cycle after reset");

endmodule

bind axil_bar_router router_sva u_router_sva (
  .clk          (clk),
  .reset_n      (reset_n),
  .wr_active    (wr_active),
  .rd_active    (rd_active),
  .s_aw_ready   (s_aw_ready),
  .s_w_ready    (s_w_ready),
  .s_ar_ready   (s_ar_ready),
  .s_b_valid    (s_b_valid),
  .s_r_valid    (s_r_valid),
  .mb_aw_valid  (mb_aw_valid),
  .mb_w_valid   (mb_w_valid),
  .mb_ar_valid  (mb_ar_valid),
  .ext_aw_valid (ext_aw_valid),
  .ext_w_valid  (ext_w_valid),
  .ext_ar_valid (ext_ar_valid)
);

// File: dv/router_checker.sv
`timescale 1ns/1ps

module router_checker
  import axil_route_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,

  // expectations for the row in flight
  input  int                row_idx,
  input  logic              exp_mb,
  input  axil_aw_t          exp_req,
  input  axil_w_t           exp_w,
  input  logic [data_w-1:0] exp_data,

  // slave side responses
  input  axil_b_t           s_b,
  input  logic              s_b_valid,
  input  logic              s_b_ready,
  input  axil_r_t           s_r,
  input  logic              s_r_valid,
  input  logic              s_r_ready,

  // mailbox side requests
  input  axil_aw_t          mb_aw,
  input  logic              mb_aw_valid,
  input  logic              mb_aw_ready,
  input  axil_w_t           mb_w,
  input  logic              mb_w_valid,
  input  logic              mb_w_ready,
  input  axil_ar_t          mb_ar,
  input  logic              mb_ar_valid,
  input  logic              mb_ar_ready,

  // external side requests
  input  axil_aw_t          ext_aw,
  input  logic              ext_aw_valid,
  input  logic              ext_aw_ready,
  input  axil_w_t           ext_w,
  input  logic              ext_w_valid,
  input  logic              ext_w_ready,
  input  axil_ar_t          ext_ar,
  input  logic              ext_ar_valid,
  input  logic              ext_ar_ready,

  // response readies toward the targets
  input  logic              mb_b_ready,
  input  logic              ext_b_ready,
  input  logic              mb_r_ready,
  input  logic              ext_r_ready,

  output int                err_count,
  output int                done_count
);

  int errs  = 0;
  int dones = 0;

  logic [1:0]        exp_resp;
  logic [data_w-1:0] exp_rdata;
  logic              mb_aw_fire;
  logic              ext_aw_fire;
  logic              mb_w_fire;
  logic              ext_w_fire;
  logic              mb_ar_fire;
  logic              ext_ar_fire;
  logic              any_valid;

  assign err_count  = errs;
  assign done_count = dones;

  // mailbox answers okay with row data
  assign exp_resp  = exp_mb ? resp_okay : resp_slverr;
  // external answers slverr and inverts the data
  assign exp_rdata = exp_mb ? exp_data : ~exp_data;

  assign mb_aw_fire  = mb_aw_valid & mb_aw_ready;
  assign ext_aw_fire = ext_aw_valid & ext_aw_ready;
  assign mb_w_fire   = mb_w_valid & mb_w_ready;
  assign ext_w_fire  = ext_w_valid & ext_w_ready;
  assign mb_ar_fire  = mb_ar_valid & mb_ar_ready;
  assign ext_ar_fire = ext_ar_valid & ext_ar_ready;

  assign any_valid = mb_aw_valid | mb_w_valid | mb_ar_valid | ext_aw_valid
                   | ext_w_valid | ext_ar_valid | s_b_valid | s_r_valid;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s (row %0d): expected %h, actual %h", name, row_idx, expected, actual);
      errs++;
    end
  endtask

  //////////////////////////////
  // per-cycle comparison
  //////////////////////////////

  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      // router must stay quiet during reset
      if (any_valid === 1'b1)
      begin
        $display("a valid output was high while reset was asserted");
        errs++;
      end
    end
    else
    begin
      // valid only toward the expected target
      if (!exp_mb && (mb_aw_valid || mb_w_valid || mb_ar_valid))
      begin
        $display("row %0d: the mailbox port saw a request meant for the external port", row_idx);
        errs++;
      end
      if (exp_mb && (ext_aw_valid || ext_w_valid || ext_ar_valid))
      begin
        $display("row %0d: the external port saw a request meant for the mailbox", row_idx);
        errs++;
      end

      // request payloads arrive unchanged
      if (mb_aw_fire || ext_aw_fire)
      begin
        check_value("aw target", exp_mb, mb_aw_fire);
        check_value("aw payload", exp_req, mb_aw_fire ? mb_aw : ext_aw);
      end
      if (mb_w_fire || ext_w_fire)
        check_value("w payload", exp_w, mb_w_fire ? mb_w : ext_w);
      if (mb_ar_fire || ext_ar_fire)
      begin
        check_value("ar target", exp_mb, mb_ar_fire);
        check_value("ar payload", exp_req, mb_ar_fire ? mb_ar : ext_ar);
      end

      // slave-side response handshakes end a row
      if (s_b_valid && s_b_ready)
      begin
        check_value("b resp", exp_resp, s_b.resp);
        // ready reaches only the owning target
        check_value("b ready", {exp_mb, !exp_mb}, {mb_b_ready, ext_b_ready});
        dones++;
      end
      if (s_r_valid && s_r_ready)
      begin
        check_value("r data", exp_rdata, s_r.data);
        check_value("r resp", exp_resp, s_r.resp);
        check_value("r ready", {exp_mb, !exp_mb}, {mb_r_ready, ext_r_ready});
        dones++;
      end
    end
  end

endmodule

// File: rtl/axil_bar_router.sv
`timescale 1ns/1ps

module axil_bar_router
  import axil_route_pkg::*;
#(
  parameter bar_mask_t [num_pf-1:0] barlite_mb_pf = '0
)
(
  input  logic      clk,
  input  logic      reset_n,
  input  bar_attr_t bar_attr,

  // slave side, driven by the dma
  input  axil_aw_t  s_aw,
  input  logic      s_aw_valid,
  output logic      s_aw_ready,
  input  axil_w_t   s_w,
  input  logic      s_w_valid,
  output logic      s_w_ready,
  output axil_b_t   s_b,
  output logic      s_b_valid,
  input  logic      s_b_ready,
  input  axil_ar_t  s_ar,
  input  logic      s_ar_valid,
  output logic      s_ar_ready,
  output axil_r_t   s_r,
  output logic      s_r_valid,
  input  logic      s_r_ready,

  // mailbox master
  output axil_aw_t  mb_aw,
  output logic      mb_aw_valid,
  input  logic      mb_aw_ready,
  output axil_w_t   mb_w,
  output logic      mb_w_valid,
  input  logic      mb_w_ready,
  input  axil_b_t   mb_b,
  input  logic      mb_b_valid,
  output logic      mb_b_ready,
  output axil_ar_t  mb_ar,
  output logic      mb_ar_valid,
  input  logic      mb_ar_ready,
  input  axil_r_t   mb_r,
  input  logic      mb_r_valid,
  output logic      mb_r_ready,

  // external master
  output axil_aw_t  ext_aw,
  output logic      ext_aw_valid,
  input  logic      ext_aw_ready,
  output axil_w_t   ext_w,
  output logic      ext_w_valid,
  input  logic      ext_w_ready,
  input  axil_b_t   ext_b,
  input  logic      ext_b_valid,
  output logic      ext_b_ready,
  output axil_ar_t  ext_ar,
  output logic      ext_ar_valid,
  input  logic      ext_ar_ready,
  input  axil_r_t   ext_r,
  input  logic      ext_r_valid,
  output logic      ext_r_ready
);

  logic   wr_is_dma;
  logic   wr_active;
  logic   wr_done;
  route_t wr_route;
  logic   rd_is_dma;
  logic   rd_active;
  logic   rd_done;
  route_t rd_route;

  // channel ends on the slave-side response handshake
  assign wr_done = s_b_valid & s_b_ready;
  assign rd_done = s_r_valid & s_r_ready;

  //////////////////////////////
  // write path
  //////////////////////////////

  bar_decoder #(
    .barlite_mb_pf (barlite_mb_pf)
  ) u_wr_dec (
    .user     (s_aw.user),
    .bar_attr (bar_attr),
    .is_dma   (wr_is_dma)
  );

  route_hold u_wr_hold (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_valid (s_aw_valid),
    .is_dma    (wr_is_dma),
    .rsp_done  (wr_done),
    .active    (wr_active),
    .route     (wr_route)
  );

  write_steer u_wr_steer (
    .active       (wr_active),
    .route        (wr_route),
    .s_aw         (s_aw),
    .s_aw_valid   (s_aw_valid),
    .s_aw_ready   (s_aw_ready),
    .s_w          (s_w),
    .s_w_valid    (s_w_valid),
    .s_w_ready    (s_w_ready),
    .s_b          (s_b),
    .s_b_valid    (s_b_valid),
    .s_b_ready    (s_b_ready),
    .mb_aw        (mb_aw),
    .mb_aw_valid  (mb_aw_valid),
    .mb_aw_ready  (mb_aw_ready),
    .mb_w         (mb_w),
    .mb_w_valid   (mb_w_valid),
    .mb_w_ready   (mb_w_ready),
    .mb_b         (mb_b),
    .mb_b_valid   (mb_b_valid),
    .mb_b_ready   (mb_b_ready),
    .ext_aw       (ext_aw),
    .ext_aw_valid (ext_aw_valid),
    .ext_aw_ready (ext_aw_ready),
    .ext_w        (ext_w),
    .ext_w_valid  (ext_w_valid),
    .ext_w_ready  (ext_w_ready),
    .ext_b        (ext_b),
    .ext_b_valid  (ext_b_valid),
    .ext_b_ready  (ext_b_ready)
  );

  //////////////////////////////
  // read path
  //////////////////////////////

  bar_decoder #(
    .barlite_mb_pf (barlite_mb_pf)
  ) u_rd_dec (
    .user     (s_ar.user),
    .bar_attr (bar_attr),
    .is_dma   (rd_is_dma)
  );

  route_hold u_rd_hold (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_valid (s_ar_valid),
    .is_dma    (rd_is_dma),
    .rsp_done  (rd_done),
    .active    (rd_active),
    .route     (rd_route)
  );

  read_steer u_rd_steer (
    .active       (rd_active),
    .route        (rd_route),
    .s_ar         (s_ar),
    .s_ar_valid   (s_ar_valid),
    .s_ar_ready   (s_ar_ready),
    .s_r          (s_r),
    .s_r_valid    (s_r_valid),
    .s_r_ready    (s_r_ready),
    .mb_ar        (mb_ar),
    .mb_ar_valid  (mb_ar_valid),
    .mb_ar_ready  (mb_ar_ready),
    .mb_r         (mb_r),
    .mb_r_valid   (mb_r_valid),
    .mb_r_ready   (mb_r_ready),
    .ext_ar       (ext_ar),
    .ext_ar_valid (ext_ar_valid),
    .ext_ar_ready (ext_ar_ready),
    .ext_r        (ext_r),
    .ext_r_valid  (ext_r_valid),
    .ext_r_ready  (ext_r_ready)
  );

endmodule

// File: rtl/read_steer.sv
`timescale 1ns/1ps

module read_steer
  import axil_route_pkg::*;
(
  input  logic     active,
  input  route_t   route,

  // slave side, from the dma
  input  axil_ar_t s_ar,
  input  logic     s_ar_valid,
  output logic     s_ar_ready,
  output axil_r_t  s_r,
  output logic     s_r_valid,
  input  logic     s_r_ready,

  // mailbox side
  output axil_ar_t mb_ar,
  output logic     mb_ar_valid,
  input  logic     mb_ar_ready,
  input  axil_r_t  mb_r,
  input  logic     mb_r_valid,
  output logic     mb_r_ready,

  // external side
  output axil_ar_t ext_ar,
  output logic     ext_ar_valid,
  input  logic     ext_ar_ready,
  input  axil_r_t  ext_r,
  input  logic     ext_r_valid,
  output logic     ext_r_ready
);

  logic to_mb;

  assign to_mb = (route == route_mailbox);

  //////////////////////////////
  // ar channel
  //////////////////////////////

  // address and user untouched on both sides
  assign mb_ar  = s_ar;
  assign ext_ar = s_ar;

  // valid only reaches the latched target
  assign mb_ar_valid  = active & to_mb & s_ar_valid;
  assign ext_ar_valid = active & ~to_mb & s_ar_valid;

  // held low while idle
  assign s_ar_ready = active & (to_mb ? mb_ar_ready : ext_ar_ready);

  //////////////////////////////
  // r channel
  //////////////////////////////

  // data and resp from the owning target
  assign s_r       = to_mb ? mb_r : ext_r;
  assign s_r_valid = active & (to_mb ? mb_r_valid : ext_r_valid);

  // read ready also qualified by the busy flag
  assign mb_r_ready  = active & to_mb & s_r_ready;
  assign ext_r_ready = active & ~to_mb & s_r_ready;

endmodule

// File: rtl/write_steer.sv
`timescale 1ns/1ps

module write_steer
  import axil_route_pkg::*;
(
  input  logic     active,
  input  route_t   route,

  // slave side, from the dma
  input  axil_aw_t s_aw,
  input  logic     s_aw_valid,
  output logic     s_aw_ready,
  input  axil_w_t  s_w,
  input  logic     s_w_valid,
  output logic     s_w_ready,
  output axil_b_t  s_b,
  output logic     s_b_valid,
  input  logic     s_b_ready,

  // mailbox side
  output axil_aw_t mb_aw,
  output logic     mb_aw_valid,
  input  logic     mb_aw_ready,
  output axil_w_t  mb_w,
  output logic     mb_w_valid,
  input  logic     mb_w_ready,
  input  axil_b_t  mb_b,
  input  logic     mb_b_valid,
  output logic     mb_b_ready,

  // external side
  output axil_aw_t ext_aw,
  output logic     ext_aw_valid,
  input  logic     ext_aw_ready,
  output axil_w_t  ext_w,
  output logic     ext_w_valid,
  input  logic     ext_w_ready,
  input  axil_b_t  ext_b,
  input  logic     ext_b_valid,
  output logic     ext_b_ready
);

  logic to_mb;

  assign to_mb = (route == route_mailbox);

  //////////////////////////////
  // aw channel
  //////////////////////////////

  // payload goes to both, only valid is steered
  assign mb_aw  = s_aw;
  assign ext_aw = s_aw;

  assign mb_aw_valid  = active & to_mb & s_aw_valid;
  assign ext_aw_valid = active & ~to_mb & s_aw_valid;

  // no ready back to the dma until a target is latched
  assign s_aw_ready = active & (to_mb ? mb_aw_ready : ext_aw_ready);

  //////////////////////////////
  // w channel
  //////////////////////////////

  assign mb_w  = s_w;
  assign ext_w = s_w;

  assign mb_w_valid  = active & to_mb & s_w_valid;
  assign ext_w_valid = active & ~to_mb & s_w_valid;

  assign s_w_ready = active & (to_mb ? mb_w_ready : ext_w_ready);

  //////////////////////////////
  // b channel
  //////////////////////////////

  // response from the latched target
  assign s_b       = to_mb ? mb_b : ext_b;
  assign s_b_valid = active & (to_mb ? mb_b_valid : ext_b_valid);

  // ready only toward the target that owns the write
  assign mb_b_ready  = to_mb & s_b_ready;
  assign ext_b_ready = ~to_mb & s_b_ready;

endmodule

// File: rtl/route_hold.sv
`timescale 1ns/1ps

module route_hold
  import axil_route_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  // request valid at the slave side
  input  logic   req_valid,
  // decode of the current request
  input  logic   is_dma,
  // response handshake at the slave side
  input  logic   rsp_done,
  output logic   active,
  output route_t route
);

  //////////////////////////////
  // channel busy flag
  //////////////////////////////

  // response handshake frees the channel, wins over a new request
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      active <= 1'b0;
    else if (rsp_done)
      active <= 1'b0;
    else if (req_valid)
      active <= 1'b1;
  end

  //////////////////////////////
  // target latch
  //////////////////////////////

  // only sampled while idle, held for the whole transaction
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      route <= route_ext;
    else if (req_valid && !active)
      route <= is_dma ? route_mailbox : route_ext;
  end

endmodule

// File: rtl/bar_decoder.sv
`timescale 1ns/1ps

module bar_decoder
  import axil_route_pkg::*;
#(
  // extra mailbox-only bars, one mask per pf
  parameter bar_mask_t [num_pf-1:0] barlite_mb_pf = '0
)
(
  input  axil_user_t user,
  input  bar_attr_t  bar_attr,
  output logic       is_dma
);

  //////////////////////////////
  // function classification
  //////////////////////////////

  logic       fn_is_pf;
  logic [1:0] pf_idx;

  // pf numbers are 0..3, anything above is a vf
  assign fn_is_pf = (user.func[7:2] == 6'b0);
  // low bits pick the pf row
  assign pf_idx   = user.func[1:0];

  //////////////////////////////
  // bar number to one-hot
  //////////////////////////////

  logic [7:0] bar_onehot;
  bar_mask_t  cur_bar;

  always_comb
  begin
    bar_onehot = 8'h00;
    bar_onehot[user.bardec] = 1'b1;
  end

  // codes 6 and 7 fall off the top, no bar hit
  assign cur_bar = bar_onehot[bar_count-1:0];

  //////////////////////////////
  // dma bar match
  //////////////////////////////

  bar_mask_t pf_dma_bar;
  bar_mask_t vf_dma_bar;
  logic      pf_is_dma;
  logic      vf_is_dma;

  // pf dma bars from attributes plus mailbox-only bars
  assign pf_dma_bar = bar_attr.pf_barlite[pf_idx] | barlite_mb_pf[pf_idx];
  // vf bars shared across a vf group
  assign vf_dma_bar = bar_attr.pf_vf_barlite[user.vfg];

  assign pf_is_dma = |(cur_bar & pf_dma_bar);
  assign vf_is_dma = |(cur_bar & vf_dma_bar);

  // purely combinational, used the same cycle as the request
  assign is_dma = fn_is_pf ? pf_is_dma : vf_is_dma;

endmodule

// File: rtl/axil_route_pkg.sv
package axil_route_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // physical functions behind the dma
  parameter int num_pf    = 4;
  // bars per function
  parameter int bar_count = 6;
  parameter int addr_w    = 32;
  parameter int data_w    = 32;
  parameter int strb_w    = data_w / 8;

  // axi response codes
  parameter logic [1:0] resp_okay   = 2'b00;
  parameter logic [1:0] resp_slverr = 2'b10;

  // one bit per bar
  typedef logic [bar_count-1:0] bar_mask_t;

  //////////////////////////////
  // request sideband
  //////////////////////////////

  // func sits in the low byte, as the dma packs it
  typedef struct packed {
    logic [2:0] bardec;
    logic [1:0] vfg;
    logic [7:0] func;
  } axil_user_t;

  // dma bar attributes, static after configuration
  // pf_vf_barlite indexed by vf group
  typedef struct packed {
    bar_mask_t [num_pf-1:0] pf_barlite;
    bar_mask_t [3:0]        pf_vf_barlite;
  } bar_attr_t;

  //////////////////////////////
  // channel payloads
  //////////////////////////////

  // address request, same shape for aw and ar
  typedef struct packed {
    logic [addr_w-1:0] addr;
    axil_user_t        user;
  } axil_aw_t;

  typedef axil_aw_t axil_ar_t;

  // write data beat
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
  } axil_w_t;

  // write response
  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  // read response
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

  // target latched per channel
  typedef enum logic {
    route_ext     = 1'b0,
    route_mailbox = 1'b1
  } route_t;

endpackage
